//--- verilog/icache_consts.svh
/*
 * Instruction cache constants: fetch port count, address and word widths,
 * line geometry (width, count, offsets, tag) and the number of fill credits
 */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Fetch side
`define ICACHE_NR_PORTS     2
`define ICACHE_FETCH_AW     32
`define ICACHE_FETCH_DW     32

// Line geometry of the direct-mapped store
`define ICACHE_LINE_WIDTH   128
`define ICACHE_LINE_COUNT   16
`define ICACHE_LINE_ALIGN   4
`define ICACHE_FETCH_ALIGN  2
`define ICACHE_COUNT_ALIGN  4
`define ICACHE_TAG_WIDTH    24

// Credits granted by the memory after reset, also the pending FIFO depth
`define ICACHE_FILL_CREDITS 2

`endif

//--- verilog/icache_pkg.sv
/*
 * Cache-side types: address, word, line, index, tag and port mask vectors,
 * plus the lookup request and response structs used between the stages
 */
`include "icache_consts.svh"

package icache_pkg;

  typedef logic [`ICACHE_FETCH_AW-1:0]    addr_t;
  typedef logic [`ICACHE_FETCH_DW-1:0]    word_t;
  typedef logic [`ICACHE_LINE_WIDTH-1:0]  line_t;
  typedef logic [`ICACHE_COUNT_ALIGN-1:0] index_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0]   tag_t;
  // One bit per fetch port, exactly one set on a request
  typedef logic [`ICACHE_NR_PORTS-1:0]    port_id_t;

  typedef struct packed {
    addr_t    addr;
    port_id_t port_id;
    logic     bypass;
  } lookup_req_t;

  typedef struct packed {
    line_t    data;
    logic     error;
    port_id_t port_id;
  } lookup_rsp_t;

endpackage

//--- verilog/fill_pkg.sv
/*
 * Fill interface types: line request address and line response with error
 */
`include "icache_consts.svh"

package fill_pkg;

  typedef logic [`ICACHE_FETCH_AW-1:0] fill_req_t;

  // Data is kept as a plain vector so the memory side needs no cache types
  typedef struct packed {
    logic [`ICACHE_LINE_WIDTH-1:0] data;
    logic                          error;
  } fill_rsp_t;

endpackage

//--- verilog/fetch_ports.sv
/*
 * Fetch port front end: one request FSM per port, a round-robin arbiter
 * onto the lookup stream and selection of the fetch word from the line
 */
`timescale 1ns/100ps
`include "icache_consts.svh"

module fetch_ports import icache_pkg::*; (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  addr_t       [`ICACHE_NR_PORTS-1:0]  inst_addr_i,
  input  logic        [`ICACHE_NR_PORTS-1:0]  inst_cacheable_i,
  input  logic        [`ICACHE_NR_PORTS-1:0]  inst_valid_i,
  output word_t       [`ICACHE_NR_PORTS-1:0]  inst_data_o,
  output logic        [`ICACHE_NR_PORTS-1:0]  inst_error_o,
  output logic        [`ICACHE_NR_PORTS-1:0]  inst_ready_o,
  output lookup_req_t                         lookup_req_o,
  output logic                                lookup_req_valid_o,
  input  logic                                lookup_req_ready_i,
  input  lookup_rsp_t                         rsp_i,
  input  logic                                rsp_valid_i
);

  localparam int NR_PORTS = `ICACHE_NR_PORTS;
  localparam int PTR_W    = (NR_PORTS > 1) ? $clog2(NR_PORTS) : 1;
  localparam int OFF_W    = `ICACHE_LINE_ALIGN - `ICACHE_FETCH_ALIGN;

  typedef enum logic [1:0] {
    state_idle,
    state_request,
    state_wait,
    state_present
  } state_e;

  state_e                state_q [NR_PORTS];
  state_e                state_d [NR_PORTS];
  logic   [NR_PORTS-1:0] req_mask;
  logic   [NR_PORTS-1:0] grant;
  logic   [NR_PORTS-1:0] rsp_hit;
  logic   [PTR_W-1:0]    rr_q;
  logic   [PTR_W-1:0]    grant_idx;
  word_t  [NR_PORTS-1:0] data_q;
  logic   [NR_PORTS-1:0] error_q;
  logic   [OFF_W-1:0]    word_off [NR_PORTS];

  for (genvar i = 0; i < NR_PORTS; i++) begin : gen_port
    assign req_mask[i]     = (state_q[i] == state_request);
    assign rsp_hit[i]      = rsp_valid_i && rsp_i.port_id[i] && (state_q[i] == state_wait);
    assign word_off[i]     = inst_addr_i[i][`ICACHE_LINE_ALIGN-1:`ICACHE_FETCH_ALIGN];
    assign inst_ready_o[i] = (state_q[i] == state_present);
    assign inst_data_o[i]  = data_q[i];
    assign inst_error_o[i] = error_q[i];
  end

  // Search starts at the port after the last one granted
  always_comb begin
    int idx;
    grant     = '0;
    grant_idx = '0;
    for (int k = 0; k < NR_PORTS; k++) begin
      idx = (int'(rr_q) + k) % NR_PORTS;
      if (grant == '0 && req_mask[idx]) begin
        grant[idx] = 1'b1;
        grant_idx  = PTR_W'(idx);
      end
    end
  end

  always_comb begin
    lookup_req_o.addr    = {inst_addr_i[grant_idx][`ICACHE_FETCH_AW-1:`ICACHE_LINE_ALIGN],
                            {`ICACHE_LINE_ALIGN{1'b0}}};
    lookup_req_o.port_id = grant;
    lookup_req_o.bypass  = ~inst_cacheable_i[grant_idx];
  end

  assign lookup_req_valid_o = |req_mask;

  always_comb begin
    for (int i = 0; i < NR_PORTS; i++) begin
      state_d[i] = state_q[i];
      unique case (state_q[i])
        state_idle:    if (inst_valid_i[i]) state_d[i] = state_request;
        state_request: if (grant[i] && lookup_req_ready_i) state_d[i] = state_wait;
        state_wait:    if (rsp_hit[i]) state_d[i] = state_present;
        state_present: state_d[i] = state_idle;
        default:       state_d[i] = state_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NR_PORTS; i++) begin
        state_q[i] <= state_idle;
      end
      rr_q <= '0;
    end else begin
      state_q <= state_d;
      if (lookup_req_valid_o && lookup_req_ready_i) begin
        rr_q <= (grant_idx == PTR_W'(NR_PORTS - 1)) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  // The word is captured with the response and shown in the present state
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NR_PORTS; i++) begin
      if (rsp_hit[i]) begin
        data_q[i]  <= rsp_i.data[word_off[i] * `ICACHE_FETCH_DW +: `ICACHE_FETCH_DW];
        error_q[i] <= rsp_i.error;
      end
    end
  end

endmodule

//--- verilog/line_lookup.sv
/*
 * Direct-mapped line store: valid bits, tag and data arrays, a one-entry
 * lookup stage that splits hits from misses, line write-back and flush
 */
`timescale 1ns/100ps
`include "icache_consts.svh"

module line_lookup import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  lookup_req_t req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  logic        flush_valid_i,
  output logic        flush_ready_o,
  input  logic        refill_busy_i,
  input  logic        refill_rsp_valid_i,
  input  index_t      write_index_i,
  input  tag_t        write_tag_i,
  input  line_t       write_line_i,
  input  logic        write_valid_i,
  output lookup_req_t miss_req_o,
  output logic        miss_req_valid_o,
  input  logic        miss_req_ready_i,
  output lookup_rsp_t rsp_o,
  output logic        rsp_valid_o
);

  localparam int LINE_COUNT = `ICACHE_LINE_COUNT;

  logic [LINE_COUNT-1:0] valid_q;
  tag_t                  tag_array  [LINE_COUNT];
  line_t                 data_array [LINE_COUNT];

  lookup_req_t stage_req_q;
  line_t       stage_line_q;
  logic        stage_valid_q;
  logic        stage_hit_q;

  index_t req_index;
  tag_t   req_tag;
  logic   req_hit;
  logic   req_fire;
  logic   rsp_fire;
  logic   miss_fire;
  logic   stage_free;

  assign req_index = req_i.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
  assign req_tag   = req_i.addr[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_WIDTH];
  // Uncacheable fetches always go to the refill path
  assign req_hit   = valid_q[req_index] && (tag_array[req_index] == req_tag) && !req_i.bypass;

  // A refill return owns the response bus, so a hit waits in the stage
  assign rsp_fire   = stage_valid_q && stage_hit_q && !refill_rsp_valid_i;
  assign miss_fire  = miss_req_valid_o && miss_req_ready_i;
  assign stage_free = !stage_valid_q || rsp_fire || miss_fire;

  assign req_ready_o   = stage_free && !flush_valid_i;
  assign req_fire      = req_valid_i && req_ready_o;
  assign flush_ready_o = flush_valid_i && !stage_valid_q && !refill_busy_i;

  assign miss_req_o       = stage_req_q;
  assign miss_req_valid_o = stage_valid_q && !stage_hit_q;

  assign rsp_o.data    = stage_line_q;
  assign rsp_o.error   = 1'b0;
  assign rsp_o.port_id = stage_req_q.port_id;
  assign rsp_valid_o   = rsp_fire;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_valid_q <= 1'b0;
    end else if (req_fire) begin
      stage_valid_q <= 1'b1;
    end else if (rsp_fire || miss_fire) begin
      stage_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      stage_req_q  <= req_i;
      stage_hit_q  <= req_hit;
      stage_line_q <= data_array[req_index];
    end
  end

  // Flush only completes with no refill pending, so it never meets a write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (flush_ready_o) begin
      valid_q <= '0;
    end else if (write_valid_i) begin
      valid_q[write_index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_valid_i) begin
      tag_array[write_index_i]  <= write_tag_i;
      data_array[write_index_i] <= write_line_i;
    end
  end

endmodule

//--- verilog/refill_unit.sv
/*
 * Refill path: fill credit counter, FIFO of pending refills, response
 * routing back to the ports and line write-back into the store
 */
`timescale 1ns/100ps
`include "icache_consts.svh"

module refill_unit import icache_pkg::*, fill_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  lookup_req_t miss_req_i,
  input  logic        miss_req_valid_i,
  output logic        miss_req_ready_o,
  output fill_req_t   fill_req_o,
  output logic        fill_req_valid_o,
  input  logic        fill_credit_i,
  input  fill_rsp_t   fill_rsp_i,
  input  logic        fill_rsp_valid_i,
  output lookup_rsp_t rsp_o,
  output logic        rsp_valid_o,
  output index_t      write_index_o,
  output tag_t        write_tag_o,
  output line_t       write_line_o,
  output logic        write_valid_o,
  output logic        refill_busy_o
);

  localparam int DEPTH = `ICACHE_FILL_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic        [CNT_W-1:0] credit_q;
  logic        [CNT_W-1:0] count_q;
  logic        [PTR_W-1:0] wr_ptr_q;
  logic        [PTR_W-1:0] rd_ptr_q;
  lookup_req_t             pend_q [DEPTH];
  lookup_req_t             head;
  logic                    fifo_full;
  logic                    push;
  logic                    pop;

  assign fifo_full        = (count_q == CNT_W'(DEPTH));
  assign miss_req_ready_o = (credit_q != '0) && !fifo_full;
  assign push             = miss_req_valid_i && miss_req_ready_o;
  // Responses come back in request order and are always taken
  assign pop              = fill_rsp_valid_i;
  assign head             = pend_q[rd_ptr_q];

  assign fill_req_o       = miss_req_i.addr;
  assign fill_req_valid_o = push;

  assign rsp_o.data    = fill_rsp_i.data;
  assign rsp_o.error   = fill_rsp_i.error;
  assign rsp_o.port_id = head.port_id;
  assign rsp_valid_o   = fill_rsp_valid_i;

  // Bypass lines and lines with an error are handed out but never stored
  assign write_index_o = head.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
  assign write_tag_o   = head.addr[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_WIDTH];
  assign write_line_o  = fill_rsp_i.data;
  assign write_valid_o = fill_rsp_valid_i && !head.bypass && !fill_rsp_i.error;

  assign refill_busy_o = (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_q <= '0;
      count_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      credit_q <= credit_q + CNT_W'(fill_credit_i) - CNT_W'(push);
      count_q  <= count_q + CNT_W'(push) - CNT_W'(pop);
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      pend_q[wr_ptr_q] <= miss_req_i;
    end
  end

endmodule

//--- verilog/icache_top.sv
/*
 * Instruction cache top level: fetch ports, line lookup and refill unit,
 * with the shared response bus back to the ports
 */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*, fill_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  addr_t [`ICACHE_NR_PORTS-1:0]  inst_addr_i,
  input  logic  [`ICACHE_NR_PORTS-1:0]  inst_cacheable_i,
  input  logic  [`ICACHE_NR_PORTS-1:0]  inst_valid_i,
  output word_t [`ICACHE_NR_PORTS-1:0]  inst_data_o,
  output logic  [`ICACHE_NR_PORTS-1:0]  inst_error_o,
  output logic  [`ICACHE_NR_PORTS-1:0]  inst_ready_o,
  input  logic                          flush_valid_i,
  output logic                          flush_ready_o,
  output fill_req_t                     fill_req_o,
  output logic                          fill_req_valid_o,
  input  logic                          fill_credit_i,
  input  fill_rsp_t                     fill_rsp_i,
  input  logic                          fill_rsp_valid_i
);

  lookup_req_t lookup_req;
  logic        lookup_req_valid;
  logic        lookup_req_ready;
  lookup_req_t miss_req;
  logic        miss_req_valid;
  logic        miss_req_ready;
  lookup_rsp_t hit_rsp;
  logic        hit_rsp_valid;
  lookup_rsp_t refill_rsp;
  logic        refill_rsp_valid;
  lookup_rsp_t rsp;
  logic        rsp_valid;
  index_t      write_index;
  tag_t        write_tag;
  line_t       write_line;
  logic        write_valid;
  logic        refill_busy;

  // Hits are held back while a refill returns, so the two never collide
  assign rsp       = refill_rsp_valid ? refill_rsp : hit_rsp;
  assign rsp_valid = refill_rsp_valid | hit_rsp_valid;

  fetch_ports i_fetch_ports (
    .clk_i              ( clk_i            ),
    .reset_i            ( reset_i          ),
    .inst_addr_i        ( inst_addr_i      ),
    .inst_cacheable_i   ( inst_cacheable_i ),
    .inst_valid_i       ( inst_valid_i     ),
    .inst_data_o        ( inst_data_o      ),
    .inst_error_o       ( inst_error_o     ),
    .inst_ready_o       ( inst_ready_o     ),
    .lookup_req_o       ( lookup_req       ),
    .lookup_req_valid_o ( lookup_req_valid ),
    .lookup_req_ready_i ( lookup_req_ready ),
    .rsp_i              ( rsp              ),
    .rsp_valid_i        ( rsp_valid        )
  );

  line_lookup i_line_lookup (
    .clk_i              ( clk_i            ),
    .reset_i            ( reset_i          ),
    .req_i              ( lookup_req       ),
    .req_valid_i        ( lookup_req_valid ),
    .req_ready_o        ( lookup_req_ready ),
    .flush_valid_i      ( flush_valid_i    ),
    .flush_ready_o      ( flush_ready_o    ),
    .refill_busy_i      ( refill_busy      ),
    .refill_rsp_valid_i ( refill_rsp_valid ),
    .write_index_i      ( write_index      ),
    .write_tag_i        ( write_tag        ),
    .write_line_i       ( write_line       ),
    .write_valid_i      ( write_valid      ),
    .miss_req_o         ( miss_req         ),
    .miss_req_valid_o   ( miss_req_valid   ),
    .miss_req_ready_i   ( miss_req_ready   ),
    .rsp_o              ( hit_rsp          ),
    .rsp_valid_o        ( hit_rsp_valid    )
  );

  refill_unit i_refill_unit (
    .clk_i              ( clk_i            ),
    .reset_i            ( reset_i          ),
    .miss_req_i         ( miss_req         ),
    .miss_req_valid_i   ( miss_req_valid   ),
    .miss_req_ready_o   ( miss_req_ready   ),
    .fill_req_o         ( fill_req_o       ),
    .fill_req_valid_o   ( fill_req_valid_o ),
    .fill_credit_i      ( fill_credit_i    ),
    .fill_rsp_i         ( fill_rsp_i       ),
    .fill_rsp_valid_i   ( fill_rsp_valid_i ),
    .rsp_o              ( refill_rsp       ),
    .rsp_valid_o        ( refill_rsp_valid ),
    .write_index_o      ( write_index      ),
    .write_tag_o        ( write_tag        ),
    .write_line_o       ( write_line       ),
    .write_valid_o      ( write_valid      ),
    .refill_busy_o      ( refill_busy      )
  );

endmodule

//--- sim/fill_memory.sv
/*
 * Fill memory model: grants credits, answers line requests in order after a
 * fixed latency, builds line data from the address and checks credit use
 */
`timescale 1ns/100ps
`include "icache_consts.svh"

module fill_memory import fill_pkg::*; #(
  parameter int LATENCY = 4
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      gate_i,
  input  fill_req_t req_i,
  input  logic      req_valid_i,
  output logic      credit_o,
  output fill_rsp_t rsp_o,
  output logic      rsp_valid_o,
  output int        req_count_o,
  output int        violation_count_o
);

  localparam int WORDS = `ICACHE_LINE_WIDTH / 32;

  fill_req_t pend_addr [$];
  int        pend_due [$];
  int        cycle;
  int        owed;
  int        outstanding;

  // Each word is its byte address mixed with a fixed pattern
  function automatic fill_rsp_t make_line(input fill_req_t addr);
    fill_rsp_t rsp;
    for (int k = 0; k < WORDS; k++) begin
      rsp.data[k*32 +: 32] = (addr + 32'(4 * k)) ^ 32'h5a5a0000;
    end
    rsp.error = addr[31];
    return rsp;
  endfunction

  initial begin
    credit_o    = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      cycle       = 0;
      owed        = `ICACHE_FILL_CREDITS;
      outstanding = 0;
      pend_addr.delete();
      pend_due.delete();
      credit_o          <= 1'b0;
      rsp_valid_o       <= 1'b0;
      req_count_o       <= 0;
      violation_count_o <= 0;
    end else begin
      cycle = cycle + 1;
      if (req_valid_i) begin
        req_count_o <= req_count_o + 1;
        if (outstanding == 0) begin
          $display("Fill request for address %h arrived with no credit outstanding", req_i);
          violation_count_o <= violation_count_o + 1;
        end else begin
          outstanding = outstanding - 1;
        end
        pend_addr.push_back(req_i);
        pend_due.push_back(cycle + LATENCY);
      end
      // A credit goes out no earlier than the edge after its line
      credit_o <= 1'b0;
      if (gate_i && owed > 0) begin
        credit_o    <= 1'b1;
        owed        = owed - 1;
        outstanding = outstanding + 1;
      end
      rsp_valid_o <= 1'b0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        rsp_o       <= make_line(pend_addr.pop_front());
        rsp_valid_o <= 1'b1;
        void'(pend_due.pop_front());
        owed = owed + 1;
      end
    end
  end

endmodule

//--- sim/icache_tb.sv
/*
 * Instruction cache testbench: clock and reset, fill memory model, directed
 * tests for hits, misses, bypass, flush, error lines and credit stalls
 */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_tb import icache_pkg::*, fill_pkg::*; ();

  // Every fetch in every test is given up to 40 cycles
  localparam int TEST_LENGTH    = 2 + 2 + 2 * 20 + 2 + 2 + 4;
  localparam int TIMEOUT_CYCLES = TEST_LENGTH * 40;

  logic                          clk;
  logic                          reset;
  addr_t [`ICACHE_NR_PORTS-1:0]  inst_addr;
  logic  [`ICACHE_NR_PORTS-1:0]  inst_cacheable;
  logic  [`ICACHE_NR_PORTS-1:0]  inst_valid;
  word_t [`ICACHE_NR_PORTS-1:0]  inst_data;
  logic  [`ICACHE_NR_PORTS-1:0]  inst_error;
  logic  [`ICACHE_NR_PORTS-1:0]  inst_ready;
  logic                          flush_valid;
  logic                          flush_ready;
  fill_req_t                     fill_req;
  logic                          fill_req_valid;
  logic                          fill_credit;
  fill_rsp_t                     fill_rsp;
  logic                          fill_rsp_valid;
  logic                          mem_gate;
  int                            req_count;
  int                            credit_violations;
  int                            error_count;
  int                            check_count;
  int                            cycle_count;
  logic [31:0]                   rand_state;

  icache_top icache_top_inst (
    .clk_i            ( clk            ),
    .reset_i          ( reset          ),
    .inst_addr_i      ( inst_addr      ),
    .inst_cacheable_i ( inst_cacheable ),
    .inst_valid_i     ( inst_valid     ),
    .inst_data_o      ( inst_data      ),
    .inst_error_o     ( inst_error     ),
    .inst_ready_o     ( inst_ready     ),
    .flush_valid_i    ( flush_valid    ),
    .flush_ready_o    ( flush_ready    ),
    .fill_req_o       ( fill_req       ),
    .fill_req_valid_o ( fill_req_valid ),
    .fill_credit_i    ( fill_credit    ),
    .fill_rsp_i       ( fill_rsp       ),
    .fill_rsp_valid_i ( fill_rsp_valid )
  );

  fill_memory fill_memory_inst (
    .clk_i             ( clk               ),
    .reset_i           ( reset             ),
    .gate_i            ( mem_gate          ),
    .req_i             ( fill_req          ),
    .req_valid_i       ( fill_req_valid    ),
    .credit_o          ( fill_credit       ),
    .rsp_o             ( fill_rsp          ),
    .rsp_valid_o       ( fill_rsp_valid    ),
    .req_count_o       ( req_count         ),
    .violation_count_o ( credit_violations )
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a fetch or flush never completed", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Expected fetch word as the memory builds it
  function automatic word_t expected_word(input addr_t addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    check_count++;
    if (exp != act) begin
      error_count++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // All tasks start and end 1 ns after a rising edge
  task automatic fetch_one(input int port, input addr_t addr, input logic cacheable,
                           output word_t data, output logic error);
    inst_addr[port]      = addr;
    inst_cacheable[port] = cacheable;
    inst_valid[port]     = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!inst_ready[port]);
    data             = inst_data[port];
    error            = inst_error[port];
    inst_valid[port] = 1'b0;
  endtask

  task automatic launch_pair(input addr_t addr0, input addr_t addr1);
    inst_addr      = {addr1, addr0};
    inst_cacheable = 2'b11;
    inst_valid     = 2'b11;
  endtask

  task automatic collect_pair(output word_t [1:0] data, output logic [1:0] error);
    logic [1:0] done;
    done = 2'b00;
    while (done != 2'b11) begin
      @(posedge clk);
      #1;
      for (int p = 0; p < 2; p++) begin
        if (!done[p] && inst_ready[p]) begin
          data[p]       = inst_data[p];
          error[p]      = inst_error[p];
          done[p]       = 1'b1;
          inst_valid[p] = 1'b0;
        end
      end
    end
  endtask

  task automatic test_miss_then_hit();
    word_t data;
    logic  error;
    int    start;
    start = req_count;
    fetch_one(0, 32'h0000_1040, 1'b1, data, error);
    compare_word("miss word", expected_word(32'h0000_1040), data);
    compare_flag("miss error flag", 1'b0, error);
    fetch_one(0, 32'h0000_1048, 1'b1, data, error);
    compare_word("hit word", expected_word(32'h0000_1048), data);
    compare_flag("hit error flag", 1'b0, error);
    compare_count("miss then hit requests", start + 1, req_count);
  endtask

  task automatic test_uncacheable();
    word_t data;
    logic  error;
    int    start;
    start = req_count;
    for (int n = 1; n <= 2; n++) begin
      fetch_one(1, 32'h0000_2204, 1'b0, data, error);
      compare_word("uncacheable word", expected_word(32'h0000_2204), data);
      compare_count("uncacheable requests", start + n, req_count);
    end
  endtask

  task automatic test_concurrent_ports();
    addr_t       addr0;
    addr_t       addr1;
    word_t [1:0] data;
    logic  [1:0] error;
    for (int n = 0; n < 20; n++) begin
      addr0 = next_random() & 32'h7fff_fffc;
      do begin
        addr1 = next_random() & 32'h7fff_fffc;
      end while (addr1[31:4] == addr0[31:4]);
      launch_pair(addr0, addr1);
      collect_pair(data, error);
      compare_word("concurrent port 0", expected_word(addr0), data[0]);
      compare_word("concurrent port 1", expected_word(addr1), data[1]);
      compare_flag("concurrent port 0 error", 1'b0, error[0]);
      compare_flag("concurrent port 1 error", 1'b0, error[1]);
    end
  endtask

  task automatic test_flush();
    word_t data;
    logic  error;
    int    start;
    fetch_one(0, 32'h0000_3320, 1'b1, data, error);
    flush_valid = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!flush_ready);
    // Valid bits clear on the edge that ends the ready cycle
    @(posedge clk);
    #1;
    flush_valid = 1'b0;
    start = req_count;
    fetch_one(0, 32'h0000_3324, 1'b1, data, error);
    compare_word("refetch after flush", expected_word(32'h0000_3324), data);
    compare_count("requests after flush", start + 1, req_count);
  endtask

  task automatic test_error_line();
    word_t data;
    logic  error;
    int    start;
    start = req_count;
    fetch_one(1, 32'h8000_4010, 1'b1, data, error);
    compare_flag("error line flag", 1'b1, error);
    fetch_one(1, 32'h8000_4010, 1'b1, data, error);
    compare_flag("repeat error flag", 1'b1, error);
    compare_count("error line requests", start + 2, req_count);
  endtask

  task automatic test_credit_backpressure();
    word_t       word;
    logic        flag;
    word_t [1:0] data;
    logic  [1:0] error;
    logic        early;
    int          start;
    mem_gate = 1'b0;
    // Use up both credits so the cache holds none
    fetch_one(0, 32'h0000_5000, 1'b0, word, flag);
    fetch_one(0, 32'h0000_5000, 1'b0, word, flag);
    start = req_count;
    early = 1'b0;
    launch_pair(32'h7ff0_6104, 32'h7ff0_7208);
    repeat (30) begin
      @(posedge clk);
      #1;
      early = early | (|inst_ready);
    end
    compare_flag("ready while stalled", 1'b0, early);
    compare_count("requests while stalled", start, req_count);
    mem_gate = 1'b1;
    collect_pair(data, error);
    compare_word("stalled port 0", expected_word(32'h7ff0_6104), data[0]);
    compare_word("stalled port 1", expected_word(32'h7ff0_7208), data[1]);
    compare_count("requests after release", start + 2, req_count);
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    inst_addr      = '0;
    inst_cacheable = '0;
    inst_valid     = '0;
    flush_valid    = 1'b0;
    mem_gate       = 1'b1;
    error_count    = 0;
    check_count    = 0;
    cycle_count    = 0;
    rand_state     = 32'hae41;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    test_miss_then_hit();
    test_uncacheable();
    test_concurrent_ports();
    test_flush();
    test_error_line();
    test_credit_backpressure();

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d, credit violations: %0d",
             check_count, error_count, credit_violations);
    if (error_count == 0 && credit_violations == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/fill_pkg.sv
verilog/fetch_ports.sv
verilog/line_lookup.sv
verilog/refill_unit.sv
verilog/icache_top.sv
sim/fill_memory.sv
sim/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= icache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
